//--- files.f
logic/turfio_pkg.sv
logic/turfio_intercon.sv
logic/tio_id_ctrl.sv
logic/sync_clock_count.sv
logic/turf_command_decoder.sv
logic/pueo_turfio_core.sv
tb/turfio_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module turfio_tb -f files.f &&
./obj_dir/Vturfio_tb || exit 1

//--- tb/turfio_tb.sv
module turfio_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk = 1'b0;
    logic                  rst_n;
    turfio_pkg::wb_req_t   wb_req;
    turfio_pkg::wb_rsp_t   wb_rsp;
    turfio_pkg::turf_cmd_t cmd;
    turfio_pkg::trig_t     trig;
    logic                  sync;
    logic [1:0]            crate_conf;
    logic                  i2c_rdy;
    logic                  en_crate;
    logic                  en_3v3;

    // Reference model
    turfio_pkg::sysclk_count_t model_count;
    turfio_pkg::sync_offset_t  model_offset;
    logic [1:0]                model_ctrl;
    turfio_pkg::cmd_count_t    model_cmd_count;
    turfio_pkg::trig_time_t    model_last_trig;
    // Decoder output one cycle behind the command
    logic                      model_sync_pend;
    logic                      model_trig_pend;
    logic                      cmd_sync;
    logic                      cmd_trig;

    turfio_pkg::wb_data_t exp_dat;
    string                test_name;
    logic [31:0]          lfsr_q = 32'h1756_8638;
    int                   cycle_count = 0;
    logic [1:0]           typ;

    pueo_turfio_core pueo_turfio_core_inst (
        .wb_clk_i       (clk),
        .rst_n_i        (rst_n),
        .wb_req_i       (wb_req),
        .wb_rsp_o       (wb_rsp),
        .cmd_i          (cmd),
        .trig_o         (trig),
        .sync_o         (sync),
        .crate_conf_i   (crate_conf),
        .i2c_rdy_i      (i2c_rdy),
        .enable_crate_o (en_crate),
        .enable_3v3_o   (en_3v3)
    );

    // 100 ns period
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [47:0] exp_v,
                                   input logic [47:0] act_v);
        abort_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp_v, act_v));
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic turfio_pkg::wb_addr_t reg_addr(input int win, input int idx);
        return turfio_pkg::wb_addr_t'((win << turfio_pkg::SLAVE_SEL_LSB) | (idx << 2));
    endfunction

    // Register map as the bus should show it
    function automatic turfio_pkg::wb_data_t expected_read(input turfio_pkg::wb_addr_t addr);
        turfio_pkg::wb_data_t v;
        logic [9:0]           win;
        turfio_pkg::reg_idx_t idx;
        v   = '0;
        win = addr[21:12];
        idx = addr[5:2];
        if (win == 10'(turfio_pkg::SEL_ID)) begin
            if (idx == turfio_pkg::ID_REG_IDENT)   v = turfio_pkg::IDENT_WORD;
            if (idx == turfio_pkg::ID_REG_VERSION) v = turfio_pkg::DATEVERSION;
            if (idx == turfio_pkg::ID_REG_CTRL)    v = {30'b0, model_ctrl};
            if (idx == turfio_pkg::ID_REG_STATUS)  v = {29'b0, i2c_rdy, crate_conf};
        end else if (win == 10'(turfio_pkg::SEL_SYNC)) begin
            if (idx == turfio_pkg::SYNC_REG_OFFSET)   v = {28'b0, model_offset};
            if (idx == turfio_pkg::SYNC_REG_COUNT_LO) v = model_count[31:0];
            if (idx == turfio_pkg::SYNC_REG_COUNT_HI) v = {16'b0, model_count[47:32]};
        end else if (win == 10'(turfio_pkg::SEL_CMD)) begin
            if (idx == turfio_pkg::CMD_REG_COUNT)     v = model_cmd_count;
            if (idx == turfio_pkg::CMD_REG_LAST_TRIG) v = {17'b0, model_last_trig};
        end
        return v;
    endfunction

    task automatic bus_xfer(input logic we, input turfio_pkg::wb_addr_t addr,
                            input turfio_pkg::wb_data_t dat);
        logic [9:0]           win;
        turfio_pkg::reg_idx_t idx;
        win = addr[21:12];
        idx = addr[5:2];
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, dat: dat};
        // Intercon idle, request taken here
        @(posedge clk);
        exp_dat = expected_read(addr);
        if (we && win == 10'(turfio_pkg::SEL_ID) && idx == turfio_pkg::ID_REG_CTRL)
            model_ctrl = dat[1:0];
        if (we && win == 10'(turfio_pkg::SEL_SYNC) && idx == turfio_pkg::SYNC_REG_OFFSET)
            model_offset = dat[3:0];
        while (!wb_rsp.ack)
            @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
    endtask

    // One valid cycle, no back-pressure
    task automatic send_cmd(input logic [1:0] code, input logic [29:0] payload);
        @(posedge clk);
        cmd <= '{valid: 1'b1, data: {code, payload}};
        @(posedge clk);
        cmd <= '0;
    endtask

    ////////////////////////////////////////////////////////////
    // Model and checks
    ////////////////////////////////////////////////////////////

    assign cmd_sync = cmd.valid && (cmd.data[31:30] == turfio_pkg::CMD_SYNC);
    assign cmd_trig = cmd.valid && (cmd.data[31:30] == turfio_pkg::CMD_TRIG);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_count     <= '0;
            model_sync_pend <= 1'b0;
            model_trig_pend <= 1'b0;
            model_cmd_count <= '0;
            model_last_trig <= '0;
        end else begin
            model_sync_pend <= cmd_sync;
            model_trig_pend <= cmd_trig;
            // Count zero two edges after the sync command
            if (model_sync_pend)
                model_count <= '0;
            else
                model_count <= model_count + 48'd1;
            if (cmd_trig)
                model_last_trig <= cmd.data[14:0];
            // Ignored codes leave the count alone
            if (cmd_sync || cmd_trig)
                model_cmd_count <= model_cmd_count + 32'd1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        // Tests need a few hundred cycles
        if (cycle_count >= 2000)
            abort_run("Timeout, the cycle limit was reached before the tests finished");
    end

    ack_latency_chk: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_req.stb) |=> wb_rsp.ack)
        else abort_run("Request was not acked one cycle after it was seen");

    ack_width_chk: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else abort_run("Ack stayed high for more than one cycle");

    read_data_chk: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_rsp.ack && !wb_req.we) |-> (wb_rsp.dat == exp_dat))
        else report_mismatch(test_name, $sampled(exp_dat), $sampled(wb_rsp.dat));

    enable_chk: assert property (@(posedge clk) disable iff (!rst_n)
        {en_3v3, en_crate} == model_ctrl)
        else report_mismatch(test_name, $sampled(model_ctrl), $sampled({en_3v3, en_crate}));

    // Pulse where low count bits hit the offset
    sync_chk: assert property (@(posedge clk) disable iff (!rst_n)
        sync == (model_count[3:0] == model_offset))
        else report_mismatch(test_name, $sampled(model_count[3:0] == model_offset),
                             $sampled(sync));

    trig_valid_chk: assert property (@(posedge clk) disable iff (!rst_n)
        trig.valid == model_trig_pend)
        else report_mismatch(test_name, $sampled(model_trig_pend), $sampled(trig.valid));

    trig_time_chk: assert property (@(posedge clk) disable iff (!rst_n)
        model_trig_pend |-> (trig.trig_time == model_last_trig))
        else report_mismatch(test_name, $sampled(model_last_trig), $sampled(trig.trig_time));

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n        = 1'b0;
        wb_req       = '0;
        cmd          = '0;
        crate_conf   = 2'b00;
        i2c_rdy      = 1'b0;
        model_offset = '0;
        model_ctrl   = 2'b00;
        exp_dat      = '0;
        typ          = 2'b00;
        test_name    = "reset";
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Ident, version, unused index, unmapped windows
        test_name = "ident";
        bus_xfer(1'b0, reg_addr(0, turfio_pkg::ID_REG_IDENT), '0);
        bus_xfer(1'b0, reg_addr(0, turfio_pkg::ID_REG_VERSION), '0);
        bus_xfer(1'b0, reg_addr(0, 7), '0);
        bus_xfer(1'b0, reg_addr(3, 0), '0);
        bus_xfer(1'b0, reg_addr(1023, 5), '0);

        test_name = "ctrl";
        repeat (6) begin
            bus_xfer(1'b1, reg_addr(0, turfio_pkg::ID_REG_CTRL), rand_bits(32));
            bus_xfer(1'b0, reg_addr(0, turfio_pkg::ID_REG_CTRL), '0);
        end

        test_name = "status";
        repeat (6) begin
            @(posedge clk);
            crate_conf <= 2'(rand_bits(2));
            i2c_rdy    <= 1'(rand_bits(1));
            bus_xfer(1'b0, reg_addr(0, turfio_pkg::ID_REG_STATUS), '0);
        end

        // Pulse pattern after reset, then per offset
        test_name = "sync_offset";
        repeat (20) @(posedge clk);
        repeat (4) begin
            bus_xfer(1'b1, reg_addr(1, turfio_pkg::SYNC_REG_OFFSET), rand_bits(32));
            bus_xfer(1'b0, reg_addr(1, turfio_pkg::SYNC_REG_OFFSET), '0);
            repeat (20) @(posedge clk);
        end

        test_name = "sync_cmd";
        repeat (3) begin
            send_cmd(turfio_pkg::CMD_SYNC, 30'(rand_bits(30)));
            repeat (rand_bits(4)) @(posedge clk);
            bus_xfer(1'b0, reg_addr(1, turfio_pkg::SYNC_REG_COUNT_LO), '0);
            bus_xfer(1'b0, reg_addr(1, turfio_pkg::SYNC_REG_COUNT_HI), '0);
        end

        // Directed trigger and ignored codes first, then random codes
        test_name = "trig_cmd";
        send_cmd(turfio_pkg::CMD_TRIG, 30'(rand_bits(30)));
        send_cmd(turfio_pkg::CMD_RSVD, 30'(rand_bits(30)));
        send_cmd(turfio_pkg::CMD_IDLE, 30'(rand_bits(30)));
        bus_xfer(1'b0, reg_addr(2, turfio_pkg::CMD_REG_LAST_TRIG), '0);
        bus_xfer(1'b0, reg_addr(2, turfio_pkg::CMD_REG_COUNT), '0);
        repeat (12) begin
            typ = 2'(rand_bits(2));
            send_cmd(typ, 30'(rand_bits(30)));
            bus_xfer(1'b0, reg_addr(2, turfio_pkg::CMD_REG_LAST_TRIG), '0);
            bus_xfer(1'b0, reg_addr(2, turfio_pkg::CMD_REG_COUNT), '0);
        end

        repeat (4) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- logic/pueo_turfio_core.sv
module pueo_turfio_core (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,
    input  turfio_pkg::wb_req_t   wb_req_i,
    output turfio_pkg::wb_rsp_t   wb_rsp_o,
    input  turfio_pkg::turf_cmd_t cmd_i,
    output turfio_pkg::trig_t     trig_o,
    output logic                  sync_o,
    input  logic [1:0]            crate_conf_i,
    input  logic                  i2c_rdy_i,
    output logic                  enable_crate_o,
    output logic                  enable_3v3_o
);

    // Per-slave request copies and responses
    turfio_pkg::wb_req_t id_req;
    turfio_pkg::wb_req_t sync_req;
    turfio_pkg::wb_req_t cmd_req;
    turfio_pkg::wb_rsp_t id_rsp;
    turfio_pkg::wb_rsp_t sync_rsp;
    turfio_pkg::wb_rsp_t cmd_rsp;
    // Decoder to counter
    logic                cmd_sync_req;

    turfio_intercon turfio_intercon_inst (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .m_req_i    (wb_req_i),
        .m_rsp_o    (wb_rsp_o),
        .id_req_o   (id_req),
        .sync_req_o (sync_req),
        .cmd_req_o  (cmd_req),
        .id_rsp_i   (id_rsp),
        .sync_rsp_i (sync_rsp),
        .cmd_rsp_i  (cmd_rsp)
    );

    // Window 0
    tio_id_ctrl tio_id_ctrl_inst (
        .wb_clk_i       (wb_clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (id_req),
        .rsp_o          (id_rsp),
        .crate_conf_i   (crate_conf_i),
        .i2c_rdy_i      (i2c_rdy_i),
        .enable_crate_o (enable_crate_o),
        .enable_3v3_o   (enable_3v3_o)
    );

    // Window 1
    sync_clock_count sync_clock_count_inst (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (sync_req),
        .rsp_o      (sync_rsp),
        .sync_req_i (cmd_sync_req),
        .sync_o     (sync_o)
    );

    // Window 2
    turf_command_decoder turf_command_decoder_inst (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .cmd_i      (cmd_i),
        .req_i      (cmd_req),
        .rsp_o      (cmd_rsp),
        .sync_req_o (cmd_sync_req),
        .trig_o     (trig_o)
    );

endmodule

//--- logic/turf_command_decoder.sv
module turf_command_decoder (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,
    input  turfio_pkg::turf_cmd_t cmd_i,
    input  turfio_pkg::wb_req_t   req_i,
    output turfio_pkg::wb_rsp_t   rsp_o,
    output logic                  sync_req_o,
    output turfio_pkg::trig_t     trig_o
);

    turfio_pkg::cmd_type_t  cmd_type;
    logic                   is_sync;
    logic                   is_trig;
    logic                   sync_req_q;
    logic                   trig_valid_q;
    turfio_pkg::trig_time_t trig_time_q;
    turfio_pkg::trig_time_t last_trig_q;
    turfio_pkg::cmd_count_t cmd_count_q;
    logic                   access;
    turfio_pkg::reg_idx_t   idx;
    turfio_pkg::wb_data_t   rdata;
    turfio_pkg::wb_data_t   dat_q;
    logic                   ack_q;

    ////////////////////////////////////////////////////////////
    // Command classify
    ////////////////////////////////////////////////////////////

    assign cmd_type = turfio_pkg::cmd_type_t'(cmd_i.data[turfio_pkg::CMD_TYPE_LSB +: 2]);
    // Idle and reserved codes dropped
    assign is_sync  = cmd_i.valid && (cmd_type == turfio_pkg::CMD_SYNC);
    assign is_trig  = cmd_i.valid && (cmd_type == turfio_pkg::CMD_TRIG);

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_req_q   <= 1'b0;
            trig_valid_q <= 1'b0;
            last_trig_q  <= '0;
            cmd_count_q  <= '0;
            ack_q        <= 1'b0;
        end else begin
            sync_req_q   <= is_sync;
            trig_valid_q <= is_trig;
            ack_q        <= access;
            if (is_trig)
                last_trig_q <= cmd_i.data[$bits(turfio_pkg::trig_time_t)-1:0];
            // Wraps at 32 bits
            if (is_sync || is_trig)
                cmd_count_q <= cmd_count_q + 1'b1;
        end
    end

    // Trigger time payload
    always_ff @(posedge wb_clk_i) begin
        if (is_trig)
            trig_time_q <= cmd_i.data[$bits(turfio_pkg::trig_time_t)-1:0];
    end

    assign sync_req_o       = sync_req_q;
    assign trig_o.valid     = trig_valid_q;
    assign trig_o.trig_time = trig_time_q;

    ////////////////////////////////////////////////////////////
    // Register readback, nothing writable
    ////////////////////////////////////////////////////////////

    assign access = req_i.cyc && req_i.stb;
    assign idx    = req_i.addr[turfio_pkg::REG_IDX_LSB +: $bits(turfio_pkg::reg_idx_t)];

    always_comb begin
        rdata = '0;
        case (idx)
            turfio_pkg::CMD_REG_COUNT:     rdata = cmd_count_q;
            turfio_pkg::CMD_REG_LAST_TRIG: rdata[14:0] = last_trig_q;
            default:                       rdata = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (access)
            dat_q <= rdata;
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = dat_q;

endmodule

//--- logic/sync_clock_count.sv
module sync_clock_count (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    input  turfio_pkg::wb_req_t req_i,
    output turfio_pkg::wb_rsp_t rsp_o,
    input  logic                sync_req_i,
    output logic                sync_o
);

    logic                      access;
    logic                      wr;
    turfio_pkg::reg_idx_t      idx;
    turfio_pkg::wb_data_t      rdata;
    turfio_pkg::wb_data_t      dat_q;
    logic                      ack_q;
    turfio_pkg::sysclk_count_t count_q;
    turfio_pkg::sync_offset_t  offset_q;

    assign access = req_i.cyc && req_i.stb;
    assign wr     = access && req_i.we;
    assign idx    = req_i.addr[turfio_pkg::REG_IDX_LSB +: $bits(turfio_pkg::reg_idx_t)];

    // One pulse per 16-cycle period
    assign sync_o = (count_q[$bits(turfio_pkg::sync_offset_t)-1:0] == offset_q);

    always_comb begin
        rdata = '0;
        case (idx)
            turfio_pkg::SYNC_REG_OFFSET:   rdata[3:0] = offset_q;
            turfio_pkg::SYNC_REG_COUNT_LO: rdata = count_q[31:0];
            // Upper 16 bits of count
            turfio_pkg::SYNC_REG_COUNT_HI: rdata[15:0] = count_q[47:32];
            default:                       rdata = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            count_q  <= '0;
            offset_q <= '0;
        end else begin
            ack_q <= access;
            // Sync request restarts the count
            if (sync_req_i)
                count_q <= '0;
            else
                count_q <= count_q + 1'b1;
            if (wr && (idx == turfio_pkg::SYNC_REG_OFFSET))
                offset_q <= req_i.dat[$bits(turfio_pkg::sync_offset_t)-1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access)
            dat_q <= rdata;
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = dat_q;

endmodule

//--- logic/tio_id_ctrl.sv
module tio_id_ctrl (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    input  turfio_pkg::wb_req_t req_i,
    output turfio_pkg::wb_rsp_t rsp_o,
    input  logic [1:0]          crate_conf_i,
    input  logic                i2c_rdy_i,
    output logic                enable_crate_o,
    output logic                enable_3v3_o
);

    logic                 access;
    logic                 wr;
    turfio_pkg::reg_idx_t idx;
    turfio_pkg::wb_data_t rdata;
    turfio_pkg::wb_data_t dat_q;
    logic                 ack_q;
    // Bit 0 crate enable, bit 1 3V3 enable
    logic [1:0]           ctrl_q;

    // Strobe already gated per window
    assign access = req_i.cyc && req_i.stb;
    assign wr     = access && req_i.we;
    assign idx    = req_i.addr[turfio_pkg::REG_IDX_LSB +: $bits(turfio_pkg::reg_idx_t)];

    // Read mux
    always_comb begin
        rdata = '0;
        case (idx)
            turfio_pkg::ID_REG_IDENT:   rdata = turfio_pkg::IDENT_WORD;
            turfio_pkg::ID_REG_VERSION: rdata = turfio_pkg::DATEVERSION;
            turfio_pkg::ID_REG_CTRL:    rdata[1:0] = ctrl_q;
            // Conf low, I2C ready above
            turfio_pkg::ID_REG_STATUS:  rdata[2:0] = {i2c_rdy_i, crate_conf_i};
            default:                    rdata = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            ctrl_q <= 2'b00;
        end else begin
            ack_q <= access;
            if (wr && (idx == turfio_pkg::ID_REG_CTRL))
                ctrl_q <= req_i.dat[1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access)
            dat_q <= rdata;
    end

    assign rsp_o.ack      = ack_q;
    assign rsp_o.dat      = dat_q;
    assign enable_crate_o = ctrl_q[0];
    assign enable_3v3_o   = ctrl_q[1];

    // Intercon must not restrobe a held request
    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        ack_q |=> !ack_q)
        else $error("tio_id_ctrl: ack high two cycles running");

endmodule

//--- logic/turfio_intercon.sv
module turfio_intercon (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    input  turfio_pkg::wb_req_t m_req_i,
    output turfio_pkg::wb_rsp_t m_rsp_o,
    output turfio_pkg::wb_req_t id_req_o,
    output turfio_pkg::wb_req_t sync_req_o,
    output turfio_pkg::wb_req_t cmd_req_o,
    input  turfio_pkg::wb_rsp_t id_rsp_i,
    input  turfio_pkg::wb_rsp_t sync_rsp_i,
    input  turfio_pkg::wb_rsp_t cmd_rsp_i
);

    // WAIT_ACK keeps a held request from going out twice
    typedef enum logic {
        IDLE,
        WAIT_ACK
    } state_t;

    state_t                       state_q;
    turfio_pkg::slave_sel_t       sel_d;
    turfio_pkg::slave_sel_t       sel_q;
    logic [turfio_pkg::WIN_W-1:0] win;
    logic                         start;
    logic                         unmap_ack_q;

    ////////////////////////////////////////////////////////////
    // Window decode
    ////////////////////////////////////////////////////////////

    assign win   = m_req_i.addr[turfio_pkg::SLAVE_SEL_LSB +: turfio_pkg::WIN_W];
    // New transfer only from IDLE
    assign start = (state_q == IDLE) && m_req_i.cyc && m_req_i.stb;

    always_comb begin
        // Anything past the last slave is unmapped
        if (win < turfio_pkg::WIN_W'(turfio_pkg::SEL_NONE))
            sel_d = turfio_pkg::slave_sel_t'(win);
        else
            sel_d = turfio_pkg::SEL_NONE;
    end

    // Fan out, strobe only to the decoded slave
    always_comb begin
        id_req_o       = m_req_i;
        sync_req_o     = m_req_i;
        cmd_req_o      = m_req_i;
        id_req_o.stb   = start && (sel_d == turfio_pkg::SEL_ID);
        sync_req_o.stb = start && (sel_d == turfio_pkg::SEL_SYNC);
        cmd_req_o.stb  = start && (sel_d == turfio_pkg::SEL_CMD);
    end

    ////////////////////////////////////////////////////////////
    // Transfer FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            sel_q       <= turfio_pkg::SEL_NONE;
            unmap_ack_q <= 1'b0;
        end else begin
            // Own ack for unmapped windows, one cycle on
            unmap_ack_q <= start && (sel_d == turfio_pkg::SEL_NONE);
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= WAIT_ACK;
                        sel_q   <= sel_d;
                    end
                end
                WAIT_ACK: begin
                    if (m_rsp_o.ack)
                        state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Response from the slave latched at start
    always_comb begin
        case (sel_q)
            turfio_pkg::SEL_ID:   m_rsp_o = id_rsp_i;
            turfio_pkg::SEL_SYNC: m_rsp_o = sync_rsp_i;
            turfio_pkg::SEL_CMD:  m_rsp_o = cmd_rsp_i;
            default: begin
                m_rsp_o.ack = unmap_ack_q;
                m_rsp_o.dat = '0;
            end
        endcase
    end

    // Slave acks must only land while a transfer is open
    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (state_q == IDLE) |-> !m_rsp_o.ack)
        else $error("intercon: ack seen while idle");

endmodule

//--- logic/turfio_pkg.sv
package turfio_pkg;

    ////////////////////////////////////////////////////////////
    // Bus types
    ////////////////////////////////////////////////////////////

    // Byte address and data words
    typedef logic [21:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // Master request, fields held until ack
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t addr;
        wb_data_t dat;
    } wb_req_t;

    // Slave response
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // Register index inside a 4 KB window
    typedef logic [3:0] reg_idx_t;
    localparam int REG_IDX_LSB = 2;

    // Window select, everything from bit 12 up
    localparam int SLAVE_SEL_LSB = 12;
    localparam int WIN_W         = $bits(wb_addr_t) - SLAVE_SEL_LSB;
    typedef logic [1:0] slave_sel_t;
    localparam slave_sel_t SEL_ID   = 2'd0;
    localparam slave_sel_t SEL_SYNC = 2'd1;
    localparam slave_sel_t SEL_CMD  = 2'd2;
    // Window 3 and above, answered by the intercon
    localparam slave_sel_t SEL_NONE = 2'd3;

    ////////////////////////////////////////////////////////////
    // Identification
    ////////////////////////////////////////////////////////////

    localparam wb_data_t    IDENT_WORD    = "TFIO";
    localparam logic [3:0]  VER_MAJOR     = 4'd0;
    localparam logic [3:0]  VER_MINOR     = 4'd0;
    localparam logic [7:0]  VER_REV       = 8'd32;
    localparam logic [15:0] FIRMWARE_DATE = 16'h0000;
    // Date on top, version below
    localparam wb_data_t DATEVERSION = {FIRMWARE_DATE, VER_MAJOR, VER_MINOR, VER_REV};

    // ID window registers
    localparam reg_idx_t ID_REG_IDENT   = 4'd0;
    localparam reg_idx_t ID_REG_VERSION = 4'd1;
    localparam reg_idx_t ID_REG_CTRL    = 4'd2;
    localparam reg_idx_t ID_REG_STATUS  = 4'd3;

    ////////////////////////////////////////////////////////////
    // Sync and clock counter
    ////////////////////////////////////////////////////////////

    typedef logic [47:0] sysclk_count_t;
    typedef logic [3:0]  sync_offset_t;
    localparam reg_idx_t SYNC_REG_OFFSET   = 4'd0;
    localparam reg_idx_t SYNC_REG_COUNT_LO = 4'd1;
    localparam reg_idx_t SYNC_REG_COUNT_HI = 4'd2;

    ////////////////////////////////////////////////////////////
    // TURF commands
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } turf_cmd_t;

    typedef logic [14:0] trig_time_t;
    typedef struct packed {
        logic       valid;
        trig_time_t trig_time;
    } trig_t;

    // Type field sits in the top two command bits
    localparam int CMD_TYPE_LSB = 30;
    typedef enum logic [1:0] {
        CMD_IDLE = 2'd0,
        CMD_SYNC = 2'd1,
        CMD_TRIG = 2'd2,
        CMD_RSVD = 2'd3
    } cmd_type_t;

    typedef logic [31:0] cmd_count_t;
    localparam reg_idx_t CMD_REG_COUNT     = 4'd0;
    localparam reg_idx_t CMD_REG_LAST_TRIG = 4'd1;

endpackage
